//--- src/aluPkg.sv
// data word type, ALU opcode numbering and the carry/zero/sign flag bundle

package aluPkg;

	parameter int DATA_BITS = 16;

	typedef logic [DATA_BITS-1:0] wordT;

	// the reserved codes keep their slots so the numbering has gaps
	typedef enum logic [4:0] {
		opMove     = 5'd0,
		opAdd      = 5'd1,
		opAdc      = 5'd2,
		opSub      = 5'd3,
		opSbb      = 5'd4,
		opAnd      = 5'd5,
		opOr       = 5'd6,
		opXor      = 5'd7,
		opMul      = 5'd8,	// reserved
		opMuls     = 5'd9,	// reserved
		opBsr      = 5'd10,	// reserved barrel shift
		opBsl      = 5'd11,	// reserved barrel shift
		opCmp      = 5'd12,
		opTest     = 5'd13,
		opRes14    = 5'd14,
		opRes15    = 5'd15,
		opAsr      = 5'd16,
		opLsr      = 5'd17,
		opLsl      = 5'd18,
		opRolc     = 5'd19,
		opRorc     = 5'd20,
		opRol      = 5'd21,	// reserved plain rotate
		opRor      = 5'd22,	// reserved plain rotate
		opClrCarry = 5'd23,
		opSetCarry = 5'd24,
		opClrZero  = 5'd25,
		opSetZero  = 5'd26,
		opClrSign  = 5'd27,
		opSetSign  = 5'd28
	} aluOpT;

	typedef struct packed {
		logic carry;
		logic zero;
		logic sign;
	} flagsT;

endpackage

//--- src/instrPkg.sv
// instruction format handed over by the host and the register index type

package instrPkg;

	import aluPkg::*;

	parameter int REG_IDX_BITS = 4;

	typedef logic [REG_IDX_BITS-1:0] regIdxT;

	// one instruction as it sits on the req/ack port
	typedef struct packed {
		aluOpT  op;
		regIdxT dst;	// also operand A
		regIdxT src;	// operand B unless useImm is set
		logic   useImm;
		wordT   imm;
	} instrT;

endpackage

//--- src/alu.sv
// registered ALU with carry/zero/sign flag memory
// operands and opcode are captured, result and flags follow one cycle later

`timescale 1ns/1ps

module alu #(
	parameter int BITS = aluPkg::DATA_BITS
) (
	input  logic          CLK,
	input  logic          RSTb,
	input  aluPkg::wordT  aIn,
	input  aluPkg::wordT  bIn,
	input  aluPkg::aluOpT opIn,
	output aluPkg::wordT  aluOut,
	output aluPkg::flagsT flags
);
	import aluPkg::*;

	logic [BITS-1:0] a;
	logic [BITS-1:0] b;
	aluOpT           op;
	logic [BITS-1:0] outReg;
	flagsT           flagReg;

	logic [BITS-1:0] outNext;
	flagsT           flagNext;

	logic            carryIn;
	logic            borrowIn;
	logic [BITS:0]   sum;
	logic [BITS:0]   diff;
	logic [BITS-1:0] andRes;
	logic [BITS-1:0] orRes;
	logic [BITS-1:0] xorRes;
	logic [BITS-1:0] asrRes;
	logic [BITS-1:0] lsrRes;
	logic [BITS-1:0] lslRes;
	logic [BITS-1:0] rolcRes;
	logic [BITS-1:0] rorcRes;

	// all three flags from an arithmetic result with its carry/borrow bit on top
	function automatic flagsT arithFlags(input logic [BITS:0] r);
		flagsT f;
		f.carry = r[BITS];
		f.zero  = ~|r[BITS-1:0];
		f.sign  = r[BITS-1];
		return f;
	endfunction

	// ------------------------------------------------------------
	// operation results
	// ------------------------------------------------------------

	assign carryIn  = (op == opAdc) & flagReg.carry;
	assign borrowIn = (op == opSbb) & flagReg.carry;	// carry doubles as borrow

	assign sum  = {1'b0, a} + {1'b0, b} + {{BITS{1'b0}}, carryIn};
	assign diff = {1'b0, a} - {1'b0, b} - {{BITS{1'b0}}, borrowIn};

	assign andRes = a & b;
	assign orRes  = a | b;
	assign xorRes = a ^ b;

	// single-bit shifts act on operand B
	assign asrRes  = {b[BITS-1], b[BITS-1:1]};
	assign lsrRes  = {1'b0, b[BITS-1:1]};
	assign lslRes  = {b[BITS-2:0], 1'b0};
	assign rolcRes = {b[BITS-2:0], flagReg.carry};
	assign rorcRes = {flagReg.carry, b[BITS-1:1]};

	always_comb begin
		outNext  = '0;	// flag ops and reserved codes give zero
		flagNext = flagReg;	// flags not named by the op keep their value
		case (op)
			opMove: outNext = b;
			opAdd, opAdc: begin
				outNext  = sum[BITS-1:0];
				flagNext = arithFlags(sum);
			end
			opSub, opSbb: begin
				outNext  = diff[BITS-1:0];
				flagNext = arithFlags(diff);
			end
			opAnd: begin
				outNext       = andRes;
				flagNext.zero = ~|andRes;
			end
			opOr: begin
				outNext       = orRes;
				flagNext.zero = ~|orRes;
			end
			opXor: begin
				outNext       = xorRes;
				flagNext.zero = ~|xorRes;
			end
			opCmp: begin
				outNext  = a;	// compare only sets flags
				flagNext = arithFlags(diff);
			end
			opTest: begin
				outNext       = a;
				flagNext.zero = ~|andRes;
			end
			opAsr: begin
				outNext       = asrRes;
				flagNext.zero = ~|asrRes;
			end
			opLsr: begin
				outNext       = lsrRes;
				flagNext.zero = ~|lsrRes;
			end
			opLsl: begin
				outNext       = lslRes;
				flagNext.zero = ~|lslRes;
			end
			opRolc: begin
				outNext        = rolcRes;
				flagNext.carry = b[BITS-1];	// bit rotated out of B
			end
			opRorc: begin
				outNext        = rorcRes;
				flagNext.carry = b[0];
			end
			opClrCarry: flagNext.carry = 1'b0;
			opSetCarry: flagNext.carry = 1'b1;
			opClrZero:  flagNext.zero  = 1'b0;
			opSetZero:  flagNext.zero  = 1'b1;
			opClrSign:  flagNext.sign  = 1'b0;
			opSetSign:  flagNext.sign  = 1'b1;
			default: ;	// multiply, barrel shift, rotate, bit count
		endcase
	end

	// ------------------------------------------------------------
	// registers
	// ------------------------------------------------------------

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			op      <= opMove;
			flagReg <= '0;
		end else begin
			op      <= opIn;
			flagReg <= flagNext;
		end
	end

	always_ff @(posedge CLK) begin
		a      <= aIn;
		b      <= bIn;
		outReg <= outNext;
	end

	assign aluOut = outReg;
	assign flags  = flagReg;

	// a set/clear op shows up on its flag the cycle after it is registered
	carryOpA: assert property (@(posedge CLK) disable iff (!RSTb)
		op inside {opClrCarry, opSetCarry} |=> flags.carry == $past(op == opSetCarry));
	zeroOpA: assert property (@(posedge CLK) disable iff (!RSTb)
		op inside {opClrZero, opSetZero} |=> flags.zero == $past(op == opSetZero));
	signOpA: assert property (@(posedge CLK) disable iff (!RSTb)
		op inside {opClrSign, opSetSign} |=> flags.sign == $past(op == opSetSign));

endmodule

//--- src/regFile.sv
// register file, two combinational read ports and one clocked write port

`timescale 1ns/1ps

module regFile #(
	parameter int BITS = aluPkg::DATA_BITS,
	parameter int REGS = 16
) (
	input  logic             CLK,
	input  logic             RSTb,
	input  instrPkg::regIdxT rdA,
	input  instrPkg::regIdxT rdB,
	output aluPkg::wordT     rdDataA,
	output aluPkg::wordT     rdDataB,
	input  logic             we,
	input  instrPkg::regIdxT wrIdx,
	input  aluPkg::wordT     wrData
);

	logic [BITS-1:0] mem [REGS];

	// reads are plain lookups, a write shows up here the cycle after it lands
	assign rdDataA = mem[rdA];
	assign rdDataB = mem[rdB];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < REGS; i++) begin
				mem[i] <= '0;	// every register starts at zero
			end
		end else if (we) begin
			mem[wrIdx] <= wrData;
		end
	end

endmodule

//--- src/issueCtrl.sv
// issue controller for the four-phase req/ack handshake
// sequences operand read, ALU strobe, writeback and ack

`timescale 1ns/1ps

module issueCtrl (
	input  logic             CLK,
	input  logic             RSTb,
	input  logic             req,
	output logic             ack,
	input  instrPkg::instrT  instr,
	output instrPkg::regIdxT rdA,
	output instrPkg::regIdxT rdB,
	output aluPkg::aluOpT    opSel,
	output logic             useImm,
	output logic             we,
	output instrPkg::regIdxT wrIdx
);
	import aluPkg::*;
	import instrPkg::*;

	typedef enum logic [2:0] {
		sIdle,
		sOperands,	// register file read, ALU captures operands
		sExecute,	// ALU registers result and flags
		sWriteback,	// register write, ack rises on exit
		sWaitLow	// ack held until req drops
	} stateT;

	stateT state;
	instrT cur;
	logic  accept;
	logic  aluEn;
	logic  writesReg;

	assign accept = (state == sIdle) && req && !ack;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= sIdle;
			ack   <= 1'b0;
		end else begin
			case (state)
				sIdle: begin
					ack <= 1'b0;	// one edge after req was seen low
					if (accept) state <= sOperands;
				end
				sOperands: state <= sExecute;
				sExecute:  state <= sWriteback;
				sWriteback: begin
					ack   <= 1'b1;
					state <= sWaitLow;
				end
				sWaitLow: if (!req) state <= sIdle;
				default:  state <= sIdle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) cur <= instr;
	end

	// ------------------------------------------------------------
	// decode
	// ------------------------------------------------------------

	assign aluEn = (state == sOperands);
	assign opSel = aluEn ? cur.op : opMove;	// move outside the strobe leaves the flags alone

	always_comb begin
		case (cur.op)
			opMove, opAdd, opAdc, opSub, opSbb,
			opAnd, opOr, opXor,
			opAsr, opLsr, opLsl, opRolc, opRorc: writesReg = 1'b1;
			default:                             writesReg = 1'b0;
		endcase
	end

	assign rdA    = cur.dst;
	assign rdB    = cur.src;
	assign useImm = cur.useImm;
	assign wrIdx  = cur.dst;
	assign we     = (state == sWriteback) && writesReg;

	// the edge that raises ack must have seen req high
	ackReqA: assert property (@(posedge CLK) disable iff (!RSTb) $rose(ack) |-> $past(req));
	weOnceA: assert property (@(posedge CLK) disable iff (!RSTb) we |=> !we);

endmodule

//--- src/execCore.sv
// execute core top level, issue controller beside register file and ALU

`timescale 1ns/1ps

module execCore #(
	parameter int BITS = aluPkg::DATA_BITS
) (
	input  logic            CLK,
	input  logic            RSTb,
	input  logic            req,
	output logic            ack,
	input  instrPkg::instrT instr,
	output aluPkg::wordT    result,
	output aluPkg::flagsT   flags
);
	import aluPkg::*;
	import instrPkg::*;

	localparam int REGS = 2 ** $bits(regIdxT);

	regIdxT rdA;
	regIdxT rdB;
	regIdxT wrIdx;
	aluOpT  opSel;
	logic   useImm;
	logic   we;
	wordT   opA;
	wordT   regB;
	wordT   opB;
	wordT   aluOut;

	issueCtrl ctrl_i (
		.CLK(CLK), .RSTb(RSTb),
		.req(req), .ack(ack), .instr(instr),
		.rdA(rdA), .rdB(rdB), .opSel(opSel), .useImm(useImm),
		.we(we), .wrIdx(wrIdx)
	);

	regFile #(.BITS(BITS), .REGS(REGS)) regs_i (
		.CLK(CLK), .RSTb(RSTb),
		.rdA(rdA), .rdB(rdB), .rdDataA(opA), .rdDataB(regB),
		.we(we), .wrIdx(wrIdx), .wrData(aluOut)
	);

	assign opB = useImm ? instr.imm : regB;	// host holds instr until ack

	alu #(.BITS(BITS)) alu_i (
		.CLK(CLK), .RSTb(RSTb),
		.aIn(opA), .bIn(opB), .opIn(opSel),
		.aluOut(aluOut), .flags(flags)
	);

	// the ALU keeps moving operand B through between strobes,
	// so the result is frozen for as long as ack is up
	always_ff @(posedge CLK) begin
		if (!ack) result <= aluOut;
	end

endmodule

//--- testbench/tbExecCore.sv
// testbench for the execute core with a shadow register and flag model
// random instructions go through the req/ack handshake, checks are assertions

`timescale 1ns/1ps

module tbExecCore;
	import aluPkg::*;
	import instrPkg::*;

	localparam int LOAD_N = 16;
	localparam int RAND_N = 40;
	localparam int HOLD_N = 4;
	localparam int NUM_TX = LOAD_N + 2 * RAND_N + 6 + 2 * 11 + 1 + LOAD_N;
	localparam int TIMEOUT_CYCLES = NUM_TX * 8 + HOLD_N + 60;	// about 6 cycles per transaction

	logic  CLK;
	logic  RSTb;
	logic  req;
	logic  ack;
	instrT instr;
	wordT  result;
	flagsT flags;

	wordT   shadowRegs [16];
	flagsT  shadowFlags;
	integer seed;
	int     errors = 0;
	int     cycleCount = 0;
	logic   lastAck = 1'b0;
	logic   lastReq = 1'b0;

	aluOpT arithOps [5] = '{opAdd, opAdc, opSub, opSbb, opCmp};
	aluOpT logicOps [11] = '{opAnd, opOr, opXor, opTest, opAsr, opLsr, opLsl,
		opRolc, opRorc, opSetCarry, opClrCarry};
	aluOpT flagOps [6] = '{opClrCarry, opSetCarry, opClrZero, opSetZero, opClrSign, opSetSign};
	aluOpT reservedOps [11] = '{opMul, opMuls, opBsr, opBsl, opRes14, opRes15, opRol, opRor,
		aluOpT'(5'd29), aluOpT'(5'd30), aluOpT'(5'd31)};

	execCore #(.BITS(DATA_BITS)) dut_i (
		.CLK(CLK), .RSTb(RSTb),
		.req(req), .ack(ack), .instr(instr),
		.result(result), .flags(flags)
	);

	always #5 CLK = ~CLK;

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	function automatic void expectedOutcome(input aluOpT op, input wordT a, input wordT b,
			input flagsT fIn, output wordT r, output flagsT f);
		logic [16:0] wide;
		f = fIn;
		r = '0;	// flag ops and reserved codes give zero
		wide = '0;
		case (op)
			opMove:       r = b;
			opAdd:        wide = {1'b0, a} + {1'b0, b};
			opAdc:        wide = {1'b0, a} + {1'b0, b} + {16'd0, fIn.carry};
			opSub, opCmp: wide = {1'b0, a} - {1'b0, b};
			opSbb:        wide = {1'b0, a} - {1'b0, b} - {16'd0, fIn.carry};
			opAnd:        r = a & b;
			opOr:         r = a | b;
			opXor:        r = a ^ b;
			opTest:       r = a;
			opAsr:        r = {b[15], b[15:1]};
			opLsr:        r = {1'b0, b[15:1]};
			opLsl:        r = {b[14:0], 1'b0};
			opRolc:       r = {b[14:0], fIn.carry};
			opRorc:       r = {fIn.carry, b[15:1]};
			opClrCarry:   f.carry = 1'b0;
			opSetCarry:   f.carry = 1'b1;
			opClrZero:    f.zero = 1'b0;
			opSetZero:    f.zero = 1'b1;
			opClrSign:    f.sign = 1'b0;
			opSetSign:    f.sign = 1'b1;
			default: ;
		endcase
		if (op inside {opAdd, opAdc, opSub, opSbb, opCmp}) begin
			r = (op == opCmp) ? a : wide[15:0];
			f.carry = wide[16];	// carry out, or borrow for the subtracting ops
			f.zero = (wide[15:0] == 16'd0);
			f.sign = wide[15];
		end
		// logic ops and plain shifts only touch Z
		if (op inside {opAnd, opOr, opXor, opAsr, opLsr, opLsl}) f.zero = (r == 16'd0);
		if (op == opTest) f.zero = ((a & b) == 16'd0);
		if (op == opRolc) f.carry = b[15];
		if (op == opRorc) f.carry = b[0];
	endfunction

	function automatic logic writesRegister(input aluOpT op);
		return op inside {opMove, opAdd, opAdc, opSub, opSbb, opAnd, opOr, opXor,
			opAsr, opLsr, opLsl, opRolc, opRorc};
	endfunction

	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic instrT randomInstr(input aluOpT op);
		instrT ins;
		logic [31:0] rnd;
		rnd = $random(seed);
		ins.op = op;
		ins.dst = rnd[3:0];
		ins.src = rnd[7:4];
		ins.useImm = rnd[8];
		ins.imm = wordT'($random(seed));
		return ins;
	endfunction

	// ------------------------------------------------------------
	// one four-phase transaction, called 1 ns after a rising edge
	// ------------------------------------------------------------

	task automatic runInstr(input string name, input instrT ins, input int hold);
		wordT  a;
		wordT  b;
		wordT  expRes;
		flagsT expFlags;
		int    waitCycles;
		a = shadowRegs[ins.dst];
		b = ins.useImm ? ins.imm : shadowRegs[ins.src];
		expectedOutcome(ins.op, a, b, shadowFlags, expRes, expFlags);
		instr = ins;
		req = 1'b1;
		@(posedge CLK);	// the core accepts on this edge
		waitCycles = 0;
		do begin
			@(posedge CLK);
			#1;
			waitCycles++;
		end while (!ack);
		assert (waitCycles == 3) else begin
			errors++;
			$display("MISMATCH %s ack latency expected 3 actual %0d", name, waitCycles);
		end
		assert (result === expRes) else begin
			errors++;
			$display("MISMATCH %s op %0d result expected %h actual %h", name, ins.op, expRes, result);
		end
		assert (flags === expFlags) else begin
			errors++;
			$display("MISMATCH %s op %0d flags expected %b actual %b", name, ins.op, expFlags, flags);
		end
		shadowFlags = expFlags;
		if (writesRegister(ins.op)) shadowRegs[ins.dst] = expRes;
		repeat (hold) begin
			@(posedge CLK);
			#1;
			assert (ack && result === expRes) else begin
				errors++;
				$display("%s: ack or result changed while req was still held", name);
			end
		end
		req = 1'b0;
		@(posedge CLK);	// this edge samples req low
		#1;
		assert (ack) else begin
			errors++;
			$display("%s: ack dropped on the edge that first saw req low", name);
		end
		@(posedge CLK);
		#1;
		assert (!ack) else begin
			errors++;
			$display("%s: ack still high one cycle after req went low", name);
		end
	endtask

	task automatic readBack(input string name, input regIdxT idx);
		instrT ins;
		ins = '0;
		ins.op = opMove;	// move a register onto itself
		ins.dst = idx;
		ins.src = idx;
		runInstr(name, ins, 0);
	endtask

	// ack may only rise on an edge that saw req high
	always @(negedge CLK) begin
		if (RSTb) begin
			assert (!(ack && !lastAck) || lastReq) else begin
				errors++;
				$display("ack rose although req was low");
			end
		end
		lastAck = ack;
		lastReq = req;
	end

	always @(posedge CLK) begin
		cycleCount++;
		if (cycleCount > TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d", errors + 1);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		instrT ins;
		CLK = 1'b0;
		RSTb = 1'b0;
		req = 1'b0;
		instr = '0;
		seed = 32'h5c0d;
		shadowFlags = '0;
		foreach (shadowRegs[i]) shadowRegs[i] = '0;
		repeat (5) @(posedge CLK);
		#1 RSTb = 1'b1;
		repeat (3) begin
			@(posedge CLK);
			#1;
			assert (!ack && flags == 3'b000) else begin
				errors++;
				$display("ack or flags not cleared after reset");
			end
		end
		for (int i = 0; i < LOAD_N; i++) begin
			ins = '0;
			ins.op = opMove;
			ins.dst = regIdxT'(i);
			ins.useImm = 1'b1;
			ins.imm = wordT'($random(seed));
			runInstr("load", ins, 0);
		end
		for (int i = 0; i < RAND_N; i++) runInstr("arith", randomInstr(arithOps[pick(5)]), 0);
		foreach (flagOps[i]) runInstr("flagop", randomInstr(flagOps[i]), 0);
		for (int i = 0; i < RAND_N; i++) runInstr("logic", randomInstr(logicOps[pick(11)]), 0);
		foreach (reservedOps[i]) begin
			ins = randomInstr(reservedOps[i]);
			runInstr("reserved", ins, 0);
			readBack("reserved", ins.dst);	// destination must be untouched
		end
		runInstr("hold", randomInstr(opAdd), HOLD_N);
		for (int i = 0; i < LOAD_N; i++) readBack("readback", regIdxT'(i));
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- execCore.f
src/aluPkg.sv
src/instrPkg.sv
src/alu.sv
src/regFile.sv
src/issueCtrl.sv
src/execCore.sv
testbench/tbExecCore.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbExecCore
FILELIST  = execCore.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
